// File: include/vid_cfg.svh
`ifndef VID_CFG_SVH
`define VID_CFG_SVH

// bus and field widths
`define VID_COORD_W 12     // pixel coordinate / timing length
`define VID_CHAN_W  8      // one colour channel
`define VID_REG_W   24     // config write data
`define VID_ADDR_W  4      // config address
`define VID_PAT_W   2      // pattern select
`define VID_SHIFT_W 4      // log2 of bar/square size

// config register map
`define VID_A_H_ACT   4'd0
`define VID_A_H_FP    4'd1
`define VID_A_H_SYNC  4'd2
`define VID_A_H_BP    4'd3
`define VID_A_V_ACT   4'd4
`define VID_A_V_FP    4'd5
`define VID_A_V_SYNC  4'd6
`define VID_A_V_BP    4'd7
`define VID_A_PATTERN 4'd8
`define VID_A_COLOR   4'd9
`define VID_A_SHIFT   4'd10
`define VID_A_ENABLE  4'd11

// 1080p timing, loaded on reset
`define VID_H_ACT_DEF  12'd1920
`define VID_H_FP_DEF   12'd88
`define VID_H_SYNC_DEF 12'd44
`define VID_H_BP_DEF   12'd148
`define VID_V_ACT_DEF  12'd1080
`define VID_V_FP_DEF   12'd4
`define VID_V_SYNC_DEF 12'd5
`define VID_V_BP_DEF   12'd36

`endif

// File: design/vid_pkg.sv
`include "vid_cfg.svh"

package vid_pkg;

  // pixel coordinate, also used for every timing length
  typedef logic [`VID_COORD_W-1:0] coord_t;

  typedef logic [`VID_CHAN_W-1:0] chan_t;  // one colour channel

  // red in [23:16], green in [15:8], blue in [7:0]
  typedef logic [3*`VID_CHAN_W-1:0] rgb_t;

  // 0 solid, 1 ramp, 2 bars, 3 checker
  typedef logic [`VID_PAT_W-1:0] pat_sel_t;

  typedef logic [`VID_SHIFT_W-1:0] shift_t;  // log2 of bar / square size

  typedef logic [`VID_ADDR_W-1:0] cfg_addr_t;  // config register address
  typedef logic [`VID_REG_W-1:0]  cfg_data_t;  // config write data

  // horizontal phases, in line order
  typedef enum logic [1:0] {
    H_ACTIVE,
    H_FRONT,
    H_SYNC,
    H_BACK
  } h_phase_e;

endpackage

// File: design/vid_if.sv
`timescale 1ns/1ps

// video mode, config regs -> sync generator
interface vid_mode_if;
  vid_pkg::coord_t h_act;   // active pixels per line
  vid_pkg::coord_t h_fp;
  vid_pkg::coord_t h_sync;
  vid_pkg::coord_t h_bp;
  vid_pkg::coord_t v_act;   // active lines per frame
  vid_pkg::coord_t v_fp;
  vid_pkg::coord_t v_sync;
  vid_pkg::coord_t v_bp;
  logic            enable;  // run the timing, else hold at (0,0)

  modport regs (
    output h_act, h_fp, h_sync, h_bp,
    output v_act, v_fp, v_sync, v_bp,
    output enable
  );

  modport timing (
    input h_act, h_fp, h_sync, h_bp,
    input v_act, v_fp, v_sync, v_bp,
    input enable
  );
endinterface

// raw timing, sync generator -> pattern generator
interface vid_timing_if;
  logic            hs;  // active high
  logic            vs;  // active high
  logic            de;
  vid_pkg::coord_t x;   // 0 outside active
  vid_pkg::coord_t y;

  modport src (output hs, vs, de, x, y);
  modport dst (input hs, vs, de, x, y);
endinterface

// File: design/vid_cfg_regs.sv
`timescale 1ns/1ps
`include "vid_cfg.svh"

module vid_cfg_regs (
  input  logic                cfg_clk,
  input  logic                reset,
  input  logic                cfg_wr,     // single-cycle write strobe
  input  vid_pkg::cfg_addr_t  cfg_addr,
  input  vid_pkg::cfg_data_t  cfg_wdata,
  vid_mode_if.regs            mode,
  output vid_pkg::pat_sel_t   pattern,
  output vid_pkg::rgb_t       color,
  output vid_pkg::shift_t     shift
);

  vid_pkg::coord_t wr_len;  // timing field, low bits of write data

  assign wr_len = cfg_wdata[`VID_COORD_W-1:0];

  // mode registers, 1080p after reset
  always_ff @(posedge cfg_clk) begin
    if (reset) begin
      mode.h_act  <= `VID_H_ACT_DEF;
      mode.h_fp   <= `VID_H_FP_DEF;
      mode.h_sync <= `VID_H_SYNC_DEF;
      mode.h_bp   <= `VID_H_BP_DEF;
      mode.v_act  <= `VID_V_ACT_DEF;
      mode.v_fp   <= `VID_V_FP_DEF;
      mode.v_sync <= `VID_V_SYNC_DEF;
      mode.v_bp   <= `VID_V_BP_DEF;
      mode.enable <= 1'b0;                   // stream stays off until written
    end else if (cfg_wr) begin
      case (cfg_addr)
        `VID_A_H_ACT:  mode.h_act  <= wr_len;
        `VID_A_H_FP:   mode.h_fp   <= wr_len;
        `VID_A_H_SYNC: mode.h_sync <= wr_len;
        `VID_A_H_BP:   mode.h_bp   <= wr_len;
        `VID_A_V_ACT:  mode.v_act  <= wr_len;
        `VID_A_V_FP:   mode.v_fp   <= wr_len;
        `VID_A_V_SYNC: mode.v_sync <= wr_len;
        `VID_A_V_BP:   mode.v_bp   <= wr_len;
        `VID_A_ENABLE: mode.enable <= cfg_wdata[0];  // bit 0 only
        default: ;                                   // pattern regs below
      endcase
    end
  end

  // pattern settings, safe to change while running
  always_ff @(posedge cfg_clk) begin
    if (reset) begin
      pattern <= '0;  // solid
      color   <= '0;  // black
      shift   <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        `VID_A_PATTERN: pattern <= cfg_wdata[`VID_PAT_W-1:0];
        `VID_A_COLOR:   color   <= cfg_wdata;               // full 24 bits, rgb order
        `VID_A_SHIFT:   shift   <= cfg_wdata[`VID_SHIFT_W-1:0];
        default: ;      // unmapped addresses dropped
      endcase
    end
  end

endmodule

// File: design/sync_vg.sv
`timescale 1ns/1ps

module sync_vg (
  input  logic         cfg_clk,
  input  logic         reset,
  vid_mode_if.timing   mode,
  vid_timing_if.src    tim
);

  vid_pkg::h_phase_e phase;       // current part of the line
  vid_pkg::h_phase_e phase_nxt;
  vid_pkg::coord_t   ph_cnt;      // position inside current phase
  vid_pkg::coord_t   ph_len;      // length of current phase
  vid_pkg::coord_t   x_cnt;       // pixel x, 0 outside active
  vid_pkg::coord_t   v_cnt;       // line number in frame
  vid_pkg::coord_t   v_fp_end;    // first sync line
  vid_pkg::coord_t   v_sync_end;  // first back porch line
  vid_pkg::coord_t   v_total;
  logic              ph_last;
  logic              line_end;
  logic              frame_end;
  logic              v_active;
  logic              v_in_sync;

  // every length must be nonzero, else the phase never ends
  always_comb begin
    case (phase)
      vid_pkg::H_ACTIVE: ph_len = mode.h_act;
      vid_pkg::H_FRONT:  ph_len = mode.h_fp;
      vid_pkg::H_SYNC:   ph_len = mode.h_sync;
      default:           ph_len = mode.h_bp;
    endcase
  end

  always_comb begin
    case (phase)
      vid_pkg::H_ACTIVE: phase_nxt = vid_pkg::H_FRONT;
      vid_pkg::H_FRONT:  phase_nxt = vid_pkg::H_SYNC;
      vid_pkg::H_SYNC:   phase_nxt = vid_pkg::H_BACK;
      default:           phase_nxt = vid_pkg::H_ACTIVE;  // next line
    endcase
  end

  assign ph_last  = (ph_cnt == ph_len - 1'b1);
  assign line_end = (phase == vid_pkg::H_BACK) && ph_last;

  // vertical region edges, in lines from frame start
  assign v_fp_end   = mode.v_act + mode.v_fp;
  assign v_sync_end = v_fp_end + mode.v_sync;
  assign v_total    = v_sync_end + mode.v_bp;

  assign frame_end = line_end && (v_cnt == v_total - 1'b1);
  assign v_active  = (v_cnt < mode.v_act);
  assign v_in_sync = (v_cnt >= v_fp_end) && (v_cnt < v_sync_end);

  // counters, parked at (0,0) while disabled
  always_ff @(posedge cfg_clk) begin
    if (reset || !mode.enable) begin
      phase  <= vid_pkg::H_ACTIVE;
      ph_cnt <= '0;
      x_cnt  <= '0;
      v_cnt  <= '0;
    end else begin
      if (ph_last) begin
        phase  <= phase_nxt;
        ph_cnt <= '0;
      end else begin
        ph_cnt <= ph_cnt + 1'b1;
      end
      // x runs only inside the active phase
      x_cnt <= (phase == vid_pkg::H_ACTIVE && !ph_last) ? x_cnt + 1'b1 : '0;
      if (line_end) begin
        v_cnt <= frame_end ? '0 : v_cnt + 1'b1;  // wrap after back porch
      end
    end
  end

  // outputs one cycle behind the counters
  always_ff @(posedge cfg_clk) begin
    if (reset || !mode.enable) begin
      tim.hs <= 1'b0;
      tim.vs <= 1'b0;
      tim.de <= 1'b0;
      tim.x  <= '0;
      tim.y  <= '0;
    end else begin
      tim.hs <= (phase == vid_pkg::H_SYNC);
      tim.vs <= v_in_sync;                            // whole lines
      tim.de <= (phase == vid_pkg::H_ACTIVE) && v_active;
      tim.x  <= (phase == vid_pkg::H_ACTIVE) ? x_cnt : '0;
      tim.y  <= v_active ? v_cnt : '0;
    end
  end

endmodule

// File: design/pattern_vg.sv
`timescale 1ns/1ps

module pattern_vg (
  input  logic               cfg_clk,
  input  logic               reset,
  vid_timing_if.dst          tim,
  input  vid_pkg::pat_sel_t  pattern,
  input  vid_pkg::rgb_t      color,
  input  vid_pkg::shift_t    shift,
  output logic               hs_out,
  output logic               vs_out,
  output logic               de_out,
  output vid_pkg::rgb_t      rgb_out
);

  localparam int CW = $bits(vid_pkg::chan_t);  // bits per channel

  vid_pkg::coord_t x_sh;     // x in units of bar / square size
  vid_pkg::coord_t y_sh;
  vid_pkg::chan_t  ramp;
  logic [2:0]      bar_idx;  // 8 bars, rgb bit per colour
  logic            chk;      // checker square is white
  vid_pkg::rgb_t   pix;

  assign x_sh    = tim.x >> shift;
  assign y_sh    = tim.y >> shift;
  assign ramp    = vid_pkg::chan_t'(tim.x);  // low bits of x
  assign bar_idx = x_sh[2:0];
  assign chk     = x_sh[0] ^ y_sh[0];         // 0 for shift past coord width

  // pixel colour, black outside active video
  always_comb begin
    pix = '0;
    if (tim.de) begin
      case (pattern)
        2'd0: pix = color;
        2'd1: pix = {ramp, ramp, ramp};     // gray ramp
        2'd2: begin
          pix = {{CW{bar_idx[2]}},          // red
                 {CW{bar_idx[1]}},          // green
                 {CW{bar_idx[0]}}};         // blue
        end
        default: pix = chk ? '1 : '0;       // white / black
      endcase
    end
  end

  // syncs delayed one cycle to line up with the pixel
  always_ff @(posedge cfg_clk) begin
    if (reset) begin
      hs_out <= 1'b0;
      vs_out <= 1'b0;
      de_out <= 1'b0;
    end else begin
      hs_out <= tim.hs;
      vs_out <= tim.vs;
      de_out <= tim.de;
    end
  end

  always_ff @(posedge cfg_clk) begin
    rgb_out <= pix;  // already zero when de low
  end

endmodule

// File: design/hdmi_top.sv
`timescale 1ns/1ps

module hdmi_top (
  input  logic                cfg_clk,
  input  logic                reset,
  // config write port
  input  logic                cfg_wr,
  input  vid_pkg::cfg_addr_t  cfg_addr,
  input  vid_pkg::cfg_data_t  cfg_wdata,
  // video out, to hdmi transmitter
  output logic                hs_out,
  output logic                vs_out,
  output logic                de_out,
  output vid_pkg::chan_t      r_out,
  output vid_pkg::chan_t      g_out,
  output vid_pkg::chan_t      b_out
);

  vid_pkg::pat_sel_t pattern;
  vid_pkg::rgb_t     color;
  vid_pkg::shift_t   shift;
  vid_pkg::rgb_t     rgb;     // packed pixel from pattern_vg

  vid_mode_if   mode ();      // regs -> sync
  vid_timing_if tim ();       // sync -> pattern

  vid_cfg_regs u_regs (
    .cfg_clk   (cfg_clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .mode      (mode.regs),
    .pattern   (pattern),
    .color     (color),
    .shift     (shift)
  );

  sync_vg u_sync (
    .cfg_clk (cfg_clk),
    .reset   (reset),
    .mode    (mode.timing),
    .tim     (tim.src)
  );

  pattern_vg u_pattern (
    .cfg_clk (cfg_clk),
    .reset   (reset),
    .tim     (tim.dst),
    .pattern (pattern),
    .color   (color),
    .shift   (shift),
    .hs_out  (hs_out),
    .vs_out  (vs_out),
    .de_out  (de_out),
    .rgb_out (rgb)
  );

  assign {r_out, g_out, b_out} = rgb;  // red in top byte

endmodule

// File: dv/hdmi_sva.sv
`timescale 1ns/1ps

module hdmi_sva (
  input logic                cfg_clk,
  input logic                reset,
  input logic                hs_out,
  input logic                vs_out,
  input logic                de_out,
  input logic                enable,   // mode.enable register
  input vid_pkg::coord_t     h_sync    // programmed sync length
);

  int unsigned     fail_cnt = 0;  // read by the testbench at the end
  vid_pkg::coord_t hs_len;        // cycles hs_out has been high so far

  always_ff @(posedge cfg_clk) begin
    if (reset || !hs_out) begin
      hs_len <= '0;
    end else begin
      hs_len <= hs_len + 1'b1;
    end
  end

  // no pixels during sync
  a_de_blank: assert property (@(posedge cfg_clk) disable iff (reset)
    de_out |-> !hs_out && !vs_out)
    else begin
      $error("de_out high together with a sync");
      fail_cnt++;
    end

  a_reset_low: assert property (@(posedge cfg_clk)
    reset |=> !de_out && !hs_out && !vs_out)
    else begin
      $error("video outputs not low after reset");
      fail_cnt++;
    end

  // a pulse cut by disable is not a full line, so only while enabled
  a_hs_len: assert property (@(posedge cfg_clk) disable iff (reset)
    $fell(hs_out) && enable |-> hs_len == h_sync)
    else begin
      $error("hs_out pulse length differs from h_sync");
      fail_cnt++;
    end

endmodule

bind hdmi_top hdmi_sva i_sva (
  .cfg_clk (cfg_clk),
  .reset   (reset),
  .hs_out  (hs_out),
  .vs_out  (vs_out),
  .de_out  (de_out),
  .enable  (mode.enable),
  .h_sync  (mode.h_sync)
);

// File: dv/hdmi_tb.sv
`timescale 1ns/1ps
`include "vid_cfg.svh"

module hdmi_tb;

  localparam int TIMEOUT = 5000;  // cycles allowed per wait
  localparam int SEL_DE  = 0;
  localparam int SEL_VS  = 1;

  logic               cfg_clk = 1'b0;
  logic               reset;
  logic               cfg_wr;
  vid_pkg::cfg_addr_t cfg_addr;
  vid_pkg::cfg_data_t cfg_wdata;
  logic               hs_out;
  logic               vs_out;
  logic               de_out;
  vid_pkg::chan_t     r_out;
  vid_pkg::chan_t     g_out;
  vid_pkg::chan_t     b_out;

  logic [31:0]       rng_state = 32'hb25c_cc5f;
  string             test_name = "reset";
  int                m_h_act, m_h_fp, m_h_sync, m_h_bp;  // programmed tiny mode
  int                m_v_act, m_v_fp, m_v_sync, m_v_bp;
  bit                running = 1'b0;  // enable written, monitor tracks x/y
  int                grace = 0;       // cycles where the old setting still counts
  int                pix_cnt = 0;
  int                mon_x = 0;
  int                mon_y = 0;
  vid_pkg::pat_sel_t exp_pattern = '0;  // matches reset values
  vid_pkg::rgb_t     exp_color = '0;
  vid_pkg::shift_t   exp_shift = '0;
  vid_pkg::pat_sel_t prev_pattern = '0;
  vid_pkg::rgb_t     prev_color = '0;
  vid_pkg::shift_t   prev_shift = '0;

  hdmi_top i_dut (
    .cfg_clk   (cfg_clk),
    .reset     (reset),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .hs_out    (hs_out),
    .vs_out    (vs_out),
    .de_out    (de_out),
    .r_out     (r_out),
    .g_out     (g_out),
    .b_out     (b_out)
  );

  always #4 cfg_clk = ~cfg_clk;  // 8 ns

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = lcg_next();
    return lo + int'(r[31:8] % (hi - lo + 1));  // upper bits, better spread
  endfunction

  // pixel colour straight from the pattern rules
  function automatic vid_pkg::rgb_t expected_pixel(input vid_pkg::pat_sel_t pattern,
      input vid_pkg::rgb_t color, input vid_pkg::shift_t shift, input int x, input int y);
    logic [7:0] lo;
    int         idx;
    lo  = x[7:0];
    idx = (x >> shift) % 8;
    case (pattern)
      2'd0: return color;
      2'd1: return {lo, lo, lo};
      2'd2: return {(idx & 4) ? 8'hff : 8'h00,
                    (idx & 2) ? 8'hff : 8'h00,
                    (idx & 1) ? 8'hff : 8'h00};
      default: return (((x >> shift) ^ (y >> shift)) & 1) ? 24'hff_ffff : 24'h0;
    endcase
  endfunction

  task automatic value_error(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR [%s] %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic plain_error(input string msg);
    $display("%s, in test %s", msg, test_name);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic write_reg(input vid_pkg::cfg_addr_t addr, input int data);
    @(posedge cfg_clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= vid_pkg::cfg_data_t'(data);
    @(posedge cfg_clk);
    cfg_wr    <= 1'b0;
  endtask

  // pattern register write, old values tolerated for a short window
  task automatic apply_setting(input vid_pkg::cfg_addr_t addr, input int data);
    @(posedge cfg_clk);
    prev_pattern = exp_pattern;
    prev_color   = exp_color;
    prev_shift   = exp_shift;
    case (addr)
      `VID_A_PATTERN: exp_pattern = vid_pkg::pat_sel_t'(data);
      `VID_A_COLOR:   exp_color   = vid_pkg::rgb_t'(data);
      default:        exp_shift   = vid_pkg::shift_t'(data);
    endcase
    grace     = 3;  // register + pixel stage + margin
    cfg_wr    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= vid_pkg::cfg_data_t'(data);
    @(posedge cfg_clk);
    cfg_wr    <= 1'b0;
  endtask

  task automatic wait_signal(input int sel, input logic level, input string what);
    int   n;
    logic v;
    n = 0;
    do begin
      @(negedge cfg_clk);
      v = (sel == SEL_DE) ? de_out : vs_out;
      n++;
      if (n > TIMEOUT) plain_error({"timeout waiting for ", what});
    end while (v !== level);
  endtask

  task automatic skip_frames(input int frames);
    repeat (frames) begin
      wait_signal(SEL_VS, 1'b1, "vs_out to rise");
      wait_signal(SEL_VS, 1'b0, "vs_out to fall");
    end
  endtask

  // one frame: burst length, gaps, bursts per frame, vsync length
  task automatic check_frame_timing();
    int   line_len;
    int   run;
    int   gap;
    int   bursts;
    int   vs_len;
    int   n;
    logic de_q;
    line_len = m_h_act + m_h_fp + m_h_sync + m_h_bp;
    run      = 0;
    gap      = -1;  // no burst seen yet
    bursts   = 0;
    n        = 0;
    de_q     = 1'b0;
    wait_signal(SEL_VS, 1'b1, "vs_out to rise");
    wait_signal(SEL_VS, 1'b0, "vs_out to fall");
    while (!vs_out) begin
      if (de_out) begin
        if (!de_q && gap >= 0) begin
          assert (gap == line_len - m_h_act)
            else value_error("gap between de bursts", line_len - m_h_act, gap);
        end
        run++;
      end else if (de_q) begin
        assert (run == m_h_act) else value_error("de cycles per line", m_h_act, run);
        bursts++;
        run = 0;
        gap = 1;
      end else if (gap >= 0) begin
        gap++;
      end
      de_q = de_out;
      n++;
      if (n > TIMEOUT) plain_error("timeout waiting for the next vs_out pulse");
      @(negedge cfg_clk);
    end
    assert (bursts == m_v_act) else value_error("active lines per frame", m_v_act, bursts);
    vs_len = 0;
    while (vs_out) begin
      vs_len++;
      if (vs_len > TIMEOUT) plain_error("timeout waiting for vs_out to fall");
      @(negedge cfg_clk);
    end
    assert (vs_len == m_v_sync * line_len)
      else value_error("vs_out cycles", m_v_sync * line_len, vs_len);
  endtask

  // pixel checker, x/y rebuilt from de_out and vs_out
  always @(negedge cfg_clk) begin : monitor
    vid_pkg::rgb_t rgb;
    vid_pkg::rgb_t want;
    vid_pkg::rgb_t was;
    rgb = {r_out, g_out, b_out};
    if (de_out !== 1'b1) begin
      assert (rgb == '0) else value_error("rgb while de_out low", 0, rgb);
    end
    if (!running) begin
      mon_x = 0;
      mon_y = 0;
    end else if (de_out) begin
      want = expected_pixel(exp_pattern, exp_color, exp_shift, mon_x, mon_y);
      was  = expected_pixel(prev_pattern, prev_color, prev_shift, mon_x, mon_y);
      assert (rgb == want || (grace > 0 && rgb == was))
        else value_error($sformatf("pixel (%0d,%0d)", mon_x, mon_y), want, rgb);
      pix_cnt++;
      mon_x++;
    end else begin
      if (mon_x != 0) mon_y++;  // line just ended
      mon_x = 0;
      if (vs_out) mon_y = 0;
    end
    if (grace > 0) grace--;
  end

  initial begin
    int start;
    int next_pat;
    reset     = 1'b1;
    cfg_wr    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (2) @(posedge cfg_clk);
    reset <= 1'b0;

    test_name = "idle";
    repeat (200) begin
      @(negedge cfg_clk);
      assert (!de_out && !hs_out && !vs_out) else plain_error("video output active before enable");
    end

    // tiny random mode, written while disabled
    test_name = "timing";
    m_h_act  = rand_range(8, 20);
    m_h_fp   = rand_range(1, 3);
    m_h_sync = rand_range(1, 4);
    m_h_bp   = rand_range(1, 3);
    m_v_act  = rand_range(3, 7);
    m_v_fp   = rand_range(1, 2);
    m_v_sync = rand_range(1, 3);
    m_v_bp   = rand_range(1, 2);
    write_reg(`VID_A_H_ACT, m_h_act);
    write_reg(`VID_A_H_FP, m_h_fp);
    write_reg(`VID_A_H_SYNC, m_h_sync);
    write_reg(`VID_A_H_BP, m_h_bp);
    write_reg(`VID_A_V_ACT, m_v_act);
    write_reg(`VID_A_V_FP, m_v_fp);
    write_reg(`VID_A_V_SYNC, m_v_sync);
    write_reg(`VID_A_V_BP, m_v_bp);
    apply_setting(`VID_A_COLOR, rand_range(0, 24'hff_ffff));
    apply_setting(`VID_A_PATTERN, 0);
    running = 1'b1;
    write_reg(`VID_A_ENABLE, 1);
    check_frame_timing();
    check_frame_timing();

    test_name = "solid";
    start = pix_cnt;
    skip_frames(2);
    assert (pix_cnt > start) else plain_error("no active pixels were seen");

    test_name = "ramp";
    apply_setting(`VID_A_PATTERN, 1);
    skip_frames(2);

    test_name = "bars";
    apply_setting(`VID_A_SHIFT, rand_range(0, 3));
    apply_setting(`VID_A_PATTERN, 2);
    skip_frames(3);  // first one may be partial

    test_name = "checker";
    apply_setting(`VID_A_SHIFT, rand_range(0, 3));
    apply_setting(`VID_A_PATTERN, 3);
    skip_frames(3);

    // switch in the middle of an active line
    test_name = "switch";
    wait_signal(SEL_DE, 1'b1, "de_out to rise");
    next_pat = (exp_pattern + 1 + rand_range(0, 2)) % 4;
    start    = pix_cnt;
    apply_setting(`VID_A_PATTERN, next_pat);
    skip_frames(2);
    assert (pix_cnt > start) else plain_error("no active pixels after the pattern change");

    repeat (4) @(posedge cfg_clk);
    if (i_dut.i_sva.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("bound assertions reported %0d failures", i_dut.i_sva.fail_cnt);
      $display("Something failed");
      $fatal(1, "stopped on assertion failures");
    end
  end

endmodule

// File: all.f
+incdir+include
design/vid_pkg.sv
design/vid_if.sv
design/vid_cfg_regs.sv
design/sync_vg.sv
design/pattern_vg.sv
design/hdmi_top.sv
dv/hdmi_sva.sv
dv/hdmi_tb.sv

// File: Bender.yml
package:
  name: hdmi_pattern_gen

export_include_dirs:
  - include

sources:
  - design/vid_pkg.sv
  - design/vid_if.sv
  - design/vid_cfg_regs.sv
  - design/sync_vg.sv
  - design/pattern_vg.sv
  - design/hdmi_top.sv
  - target: test
    files:
      - dv/hdmi_sva.sv
      - dv/hdmi_tb.sv
